// ==== flist.f ====
+incdir+verification
source/ahb_pkg.sv
source/ahb_decoder.sv
source/ahb_slave_mux.sv
source/ahb_sram.sv
source/ahb_reg_bank.sv
source/ahb_default_slave.sv
source/ahb_subsystem.sv
verification/tb_ahb_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the AHB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_ahb_subsystem \
    -f flist.f \
    -o tb_ahb_subsystem

# a failing run exits non-zero, the log search below decides the result
./obj_dir/tb_ahb_subsystem > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
    echo "run_sim: test passed"
else
    echo "run_sim: test failed"
    exit 1
fi

// ==== verification/tb_ahb_tasks.svh ====
`ifndef TB_AHB_TASKS_SVH
`define TB_AHB_TASKS_SVH

// report one failure and end the run
task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first failure");
endtask

task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        fail_stop($sformatf("** Error at %0t ns: %s is %08h, expected %08h",
                            $time, what, got, exp));
    end
endtask

task automatic check_resp(input hresp_e got, input hresp_e exp, input string what);
    if (got !== exp) begin
        fail_stop($sformatf("** Error at %0t ns: %s is %s, expected %s",
                            $time, what, got.name(), exp.name()));
    end
endtask

task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
        fail_stop($sformatf("** Error at %0t ns: %s took %0d cycles, expected %0d",
                            $time, what, got, exp));
    end
endtask

task automatic check_ready(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        fail_stop($sformatf("** Error at %0t ns: %s is %b, expected %b",
                            $time, what, got, exp));
    end
endtask

// called 1 ns after a rising edge; drives a new address phase and
// finishes the data phase of the transfer before it
task automatic issue_transfer(
    input  htrans_e     trans,
    input  logic [31:0] addr,
    input  logic        write,
    input  hsize_e      size,
    input  logic [31:0] prev_wdata,
    output logic [31:0] rdata,
    output hresp_e      resp,
    output hresp_e      first_resp,
    output int          cycles
);
    logic done;
    haddr  = addr;
    htrans = trans;
    hwrite = write;
    hsize  = size;
    hwdata = prev_wdata;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
        // mid-cycle where all outputs have settled
        @(negedge HCLK);
        cycles++;
        if (cycles == 1) begin
            first_resp = hresp;
        end
        done = hready;
        if (done) begin
            rdata = hrdata;
            resp  = hresp;
        end
        @(posedge HCLK);
        #1;
    end
endtask

`endif

// ==== verification/tb_ahb_subsystem.sv ====
module tb_ahb_subsystem import ahb_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 8;

    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        hsize_e      size;
        logic [31:0] wdata;
        logic [31:0] rdata;
        hresp_e      resp;
        int          cycles;
    } entry_t;

    logic        HCLK;
    logic        HRESETn;
    logic [31:0] haddr;
    htrans_e     htrans;
    logic        hwrite;
    hsize_e      hsize;
    logic [31:0] hwdata;
    logic        hready;
    hresp_e      hresp;
    logic [31:0] hrdata;

    entry_t      table_q[$];
    logic [31:0] sram_model [SRAM_WORDS];
    logic [31:0] reg_model [4];
    int          seed;
    logic        table_ready;

    `include "tb_ahb_tasks.svh"

    ahb_subsystem dut (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .haddr   (haddr),
        .htrans  (htrans),
        .hwrite  (hwrite),
        .hsize   (hsize),
        .hwdata  (hwdata),
        .hready  (hready),
        .hresp   (hresp),
        .hrdata  (hrdata)
    );

    always #CLK_HALF HCLK = ~HCLK;

    // little-endian lanes as on the bus
    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wdata,
                                                input hsize_e size, input logic [1:0] offset);
        logic [31:0] mask;
        case (size)
            HSIZE_BYTE: mask = 32'h0000_00FF << {offset, 3'b000};
            HSIZE_HALF: mask = offset[1] ? 32'hFFFF_0000 : 32'h0000_FFFF;
            default:    mask = 32'hFFFF_FFFF;
        endcase
        return (old & ~mask) | (wdata & mask);
    endfunction

    function automatic void push_entry(input logic [31:0] addr, input logic write,
                                       input hsize_e size, input logic [31:0] wdata,
                                       input logic [31:0] rdata, input hresp_e resp,
                                       input int cycles);
        entry_t e;
        e.addr   = addr;
        e.write  = write;
        e.size   = size;
        e.wdata  = wdata;
        e.rdata  = rdata;
        e.resp   = resp;
        e.cycles = cycles;
        table_q.push_back(e);
    endfunction

    function automatic void add_sram_write(input logic [7:0] word, input logic [1:0] offset,
                                           input hsize_e size, input logic [31:0] data);
        sram_model[word] = merge_lanes(sram_model[word], data, size, offset);
        push_entry(SRAM_BASE | {22'b0, word, offset}, 1'b1, size, data, 32'h0, HRESP_OKAY, 1);
    endfunction

    function automatic void add_sram_read(input logic [7:0] word);
        push_entry(SRAM_BASE | {22'b0, word, 2'b00}, 1'b0, HSIZE_WORD, 32'h0,
                   sram_model[word], HRESP_OKAY, 1);
    endfunction

    function automatic void add_reg_write(input logic [1:0] idx, input logic [31:0] data);
        // the id register keeps its value
        if (idx != 2'd3) begin
            reg_model[idx] = data;
        end
        push_entry(REGS_BASE | {28'b0, idx, 2'b00}, 1'b1, HSIZE_WORD, data, 32'h0,
                   HRESP_OKAY, 1);
    endfunction

    function automatic void add_reg_read(input logic [1:0] idx);
        push_entry(REGS_BASE | {28'b0, idx, 2'b00}, 1'b0, HSIZE_WORD, 32'h0,
                   reg_model[idx], HRESP_OKAY, 2);
    endfunction

    function automatic void add_unmapped(input logic [31:0] addr, input logic write);
        push_entry(addr, write, HSIZE_WORD, 32'hDEAD_0000 | {16'h0, addr[15:0]}, 32'h0,
                   HRESP_ERROR, 2);
    endfunction

    function automatic void build_table();
        logic [7:0] words [8];
        logic [7:0] w;
        for (int i = 0; i < 3; i++) begin
            reg_model[i] = 32'h0;
        end
        reg_model[3] = REG_ID_VALUE;
        // sram words at random places, then read back
        for (int i = 0; i < 8; i++) begin
            words[i] = 8'($random(seed));
            add_sram_write(words[i], 2'd0, HSIZE_WORD, $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            add_sram_read(words[i]);
        end
        // sub-word merges into one word
        add_sram_write(8'hA0, 2'd0, HSIZE_WORD, $random(seed));
        add_sram_write(8'hA0, 2'd1, HSIZE_BYTE, $random(seed));
        add_sram_write(8'hA0, 2'd3, HSIZE_BYTE, $random(seed));
        add_sram_read(8'hA0);
        add_sram_write(8'hA0, 2'd2, HSIZE_HALF, $random(seed));
        add_sram_write(8'hA0, 2'd0, HSIZE_HALF, $random(seed));
        add_sram_write(8'hA0, 2'd2, HSIZE_BYTE, $random(seed));
        add_sram_read(8'hA0);
        // register bank
        add_reg_read(2'd0);
        for (int i = 0; i < 3; i++) begin
            add_reg_write(2'(i), $random(seed));
        end
        for (int i = 0; i < 4; i++) begin
            add_reg_read(2'(i));
        end
        add_reg_write(2'd3, $random(seed));
        add_reg_read(2'd3);
        // unmapped addresses including those just past each region
        add_unmapped(32'h2000_0000, 1'b1);
        add_sram_read(words[0]);
        add_unmapped(32'h0000_0400, 1'b0);
        add_unmapped(32'h4000_0010, 1'b0);
        add_sram_read(words[1]);
        // mixed slaves back to back
        for (int k = 0; k < 4; k++) begin
            w = 8'($random(seed));
            add_sram_write(w, 2'd0, HSIZE_WORD, $random(seed));
            add_reg_read(2'(k % 3));
            add_unmapped(32'h8000_0000 | (k << 4), 1'b0);
            add_sram_read(w);
            add_reg_write(2'(k % 3), $random(seed));
            add_unmapped(32'h1000_0000 | (k << 8), 1'b1);
        end
    endfunction

    initial begin
        entry_t      prev;
        logic [31:0] prev_wdata;
        logic [31:0] rdata;
        hresp_e      resp;
        hresp_e      first_resp;
        int          cycles;
        table_ready = 1'b0;
        HCLK        = 1'b0;
        HRESETn     = 1'b0;
        haddr       = 32'h0;
        htrans      = HTRANS_IDLE;
        hwrite      = 1'b0;
        hsize       = HSIZE_WORD;
        hwdata      = 32'h0;
        seed        = 32'h1fef7ace;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge HCLK);
        #1;
        HRESETn = 1'b1;
        // idle bus straight out of reset
        @(negedge HCLK);
        check_ready(hready, 1'b1, "hready after reset");
        check_resp(hresp, HRESP_OKAY, "hresp after reset");
        check_data(hrdata, 32'h0, "hrdata after reset");
        @(posedge HCLK);
        #1;
        prev_wdata = 32'h0;
        // one extra idle step drains the last data phase
        for (int i = 0; i <= table_q.size(); i++) begin
            if (i < table_q.size()) begin
                issue_transfer(HTRANS_NONSEQ, table_q[i].addr, table_q[i].write,
                               table_q[i].size, prev_wdata, rdata, resp, first_resp,
                               cycles);
                prev_wdata = table_q[i].wdata;
            end else begin
                issue_transfer(HTRANS_IDLE, 32'h0, 1'b0, HSIZE_WORD, prev_wdata,
                               rdata, resp, first_resp, cycles);
            end
            if (i > 0) begin
                prev = table_q[i - 1];
                check_resp(first_resp, prev.resp,
                           $sformatf("entry %0d first data-phase response", i - 1));
                check_resp(resp, prev.resp, $sformatf("entry %0d response", i - 1));
                check_cycles(cycles, prev.cycles, $sformatf("entry %0d data phase", i - 1));
                if (!prev.write && prev.resp == HRESP_OKAY) begin
                    check_data(rdata, prev.rdata, $sformatf("entry %0d read data", i - 1));
                end
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

    // bus watchdog
    initial begin
        wait (table_ready);
        repeat (table_q.size() * 4 + 20) @(posedge HCLK);
        fail_stop("watchdog expired because the bus hung before the table was done");
    end

endmodule

// ==== source/ahb_subsystem.sv ====
module ahb_subsystem import ahb_pkg::*; (
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic [31:0] haddr,
    input  htrans_e     htrans,
    input  logic        hwrite,
    input  hsize_e      hsize,
    input  logic [31:0] hwdata,
    output logic        hready,
    output hresp_e      hresp,
    output logic [31:0] hrdata
);

    logic [NUM_SLAVES-1:0]    hsel;
    logic [NUM_SLAVES-1:0]    slv_hreadyout;
    hresp_e [NUM_SLAVES-1:0]  slv_hresp;
    logic [NUM_SLAVES*32-1:0] slv_hrdata;

    // default slave returns no data
    assign slv_hrdata[SLV_DEFAULT*32 +: 32] = 32'h0;

    ahb_decoder u_decoder (
        .haddr (haddr),
        .hsel  (hsel)
    );

    ahb_sram u_sram (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hsel      (hsel[SLV_SRAM]),
        .hready    (hready),
        .hwrite    (hwrite),
        .htrans    (htrans),
        .hsize     (hsize),
        .haddr     (haddr),
        .hwdata    (hwdata),
        .hreadyout (slv_hreadyout[SLV_SRAM]),
        .hresp     (slv_hresp[SLV_SRAM]),
        .hrdata    (slv_hrdata[SLV_SRAM*32 +: 32])
    );

    ahb_reg_bank u_reg_bank (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hsel      (hsel[SLV_REGS]),
        .hready    (hready),
        .hwrite    (hwrite),
        .htrans    (htrans),
        .hsize     (hsize),
        .haddr     (haddr),
        .hwdata    (hwdata),
        .hreadyout (slv_hreadyout[SLV_REGS]),
        .hresp     (slv_hresp[SLV_REGS]),
        .hrdata    (slv_hrdata[SLV_REGS*32 +: 32])
    );

    ahb_default_slave u_default_slave (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hsel      (hsel[SLV_DEFAULT]),
        .hready    (hready),
        .htrans    (htrans),
        .hreadyout (slv_hreadyout[SLV_DEFAULT]),
        .hresp     (slv_hresp[SLV_DEFAULT])
    );

    // mux output doubles as the bus-wide hready
    ahb_slave_mux u_slave_mux (
        .HCLK          (HCLK),
        .HRESETn       (HRESETn),
        .hready        (hready),
        .hsel          (hsel),
        .slv_hreadyout (slv_hreadyout),
        .slv_hresp     (slv_hresp),
        .slv_hrdata    (slv_hrdata),
        .hreadyout     (hready),
        .hresp         (hresp),
        .hrdata        (hrdata)
    );

endmodule

// ==== source/ahb_default_slave.sv ====
module ahb_default_slave import ahb_pkg::*; (
    input  logic    HCLK,
    input  logic    HRESETn,
    input  logic    hsel,
    input  logic    hready,
    input  htrans_e htrans,
    output logic    hreadyout,
    output hresp_e  hresp
);

    dflt_state_e state;
    dflt_state_e state_nxt;
    logic        active;

    assign active = hsel && hready && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state <= DFLT_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ERR2 may take a new transfer straight away
    always_comb begin
        state_nxt = state;
        hreadyout = 1'b1;
        hresp     = HRESP_OKAY;
        case (state)
            DFLT_ERR1: begin
                hreadyout = 1'b0;
                hresp     = HRESP_ERROR;
                state_nxt = DFLT_ERR2;
            end
            DFLT_ERR2: begin
                hresp     = HRESP_ERROR;
                state_nxt = active ? DFLT_ERR1 : DFLT_IDLE;
            end
            default: begin
                state_nxt = active ? DFLT_ERR1 : DFLT_IDLE;
            end
        endcase
    end

endmodule

// ==== source/ahb_reg_bank.sv ====
module ahb_reg_bank import ahb_pkg::*; (
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        hsel,
    input  logic        hready,
    input  logic        hwrite,
    input  htrans_e     htrans,
    input  hsize_e      hsize,
    input  logic [31:0] haddr,
    input  logic [31:0] hwdata,
    output logic        hreadyout,
    output hresp_e      hresp,
    output logic [31:0] hrdata
);

    logic [31:0] regs [3];

    logic       active;
    logic       wr_q;
    logic       rd_pend;
    logic [1:0] addr_q;
    logic [3:0] lanes_q;

    assign active = hsel && hready && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);

    // rd_pend drops after one cycle, giving the single read wait state
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            wr_q    <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            if (rd_pend) begin
                rd_pend <= 1'b0;
            end else if (hready) begin
                rd_pend <= active && !hwrite;
            end
            if (hready) begin
                wr_q <= active && hwrite;
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (active) begin
            addr_q  <= haddr[3:2];
            lanes_q <= byte_lanes(hsize, haddr[1:0]);
        end
    end

    // register 3 ignores writes
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            for (int i = 0; i < 3; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (wr_q && hready && addr_q != 2'd3) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes_q[i]) begin
                    regs[addr_q][i*8 +: 8] <= hwdata[i*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        case (addr_q)
            2'd0:    hrdata = regs[0];
            2'd1:    hrdata = regs[1];
            2'd2:    hrdata = regs[2];
            default: hrdata = REG_ID_VALUE;
        endcase
    end

    assign hreadyout = !rd_pend;
    assign hresp     = HRESP_OKAY;

endmodule

// ==== source/ahb_sram.sv ====
module ahb_sram import ahb_pkg::*; (
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        hsel,
    input  logic        hready,
    input  logic        hwrite,
    input  htrans_e     htrans,
    input  hsize_e      hsize,
    input  logic [31:0] haddr,
    input  logic [31:0] hwdata,
    output logic        hreadyout,
    output hresp_e      hresp,
    output logic [31:0] hrdata
);

    logic [31:0] mem [SRAM_WORDS];

    logic               active;
    logic               wr_q;
    logic [SRAM_AW-1:0] addr_q;
    logic [3:0]         lanes_q;

    assign active = hsel && hready && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);

    // write flag for the coming data phase
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            wr_q <= 1'b0;
        end else if (hready) begin
            wr_q <= active && hwrite;
        end
    end

    // address-phase payload
    always_ff @(posedge HCLK) begin
        if (active) begin
            addr_q  <= haddr[SRAM_AW+1:2];
            lanes_q <= byte_lanes(hsize, haddr[1:0]);
        end
    end

    // write lands on the edge closing the data phase
    always_ff @(posedge HCLK) begin
        if (wr_q && hready) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes_q[i]) begin
                    mem[addr_q][i*8 +: 8] <= hwdata[i*8 +: 8];
                end
            end
        end
    end

    assign hrdata    = mem[addr_q];
    assign hreadyout = 1'b1;
    assign hresp     = HRESP_OKAY;

endmodule

// ==== source/ahb_slave_mux.sv ====
module ahb_slave_mux import ahb_pkg::*; (
    input  logic                     HCLK,
    input  logic                     HRESETn,
    input  logic                     hready,
    input  logic [NUM_SLAVES-1:0]    hsel,
    input  logic [NUM_SLAVES-1:0]    slv_hreadyout,
    input  hresp_e [NUM_SLAVES-1:0]  slv_hresp,
    input  logic [NUM_SLAVES*32-1:0] slv_hrdata,
    output logic                     hreadyout,
    output hresp_e                   hresp,
    output logic [31:0]              hrdata
);

    // data-phase select, follows the address phase
    logic [NUM_SLAVES-1:0] hsel_q;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            hsel_q <= '0;
        end else if (hready) begin
            hsel_q <= hsel;
        end
    end

    // select is one-hot, so at most one slot matches
    always_comb begin
        hreadyout = 1'b1;
        hresp     = HRESP_OKAY;
        hrdata    = 32'h0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (hsel_q[i]) begin
                hreadyout = slv_hreadyout[i];
                hresp     = slv_hresp[i];
                hrdata    = slv_hrdata[i*32 +: 32];
            end
        end
    end

endmodule

// ==== source/ahb_decoder.sv ====
module ahb_decoder import ahb_pkg::*; (
    input  logic [31:0]           haddr,
    output logic [NUM_SLAVES-1:0] hsel
);

    logic hit_sram;
    logic hit_regs;

    assign hit_sram = (haddr & ~SRAM_MASK) == SRAM_BASE;
    assign hit_regs = (haddr & ~REGS_MASK) == REGS_BASE;

    // anything unmapped lands on the default slave
    always_comb begin
        hsel = '0;
        if (hit_sram) begin
            hsel[SLV_SRAM] = 1'b1;
        end else if (hit_regs) begin
            hsel[SLV_REGS] = 1'b1;
        end else begin
            hsel[SLV_DEFAULT] = 1'b1;
        end
    end

endmodule

// ==== source/ahb_pkg.sv ====
package ahb_pkg;

    // slave slots behind the mux
    localparam int NUM_SLAVES  = 3;
    localparam int SLV_SRAM    = 0;
    localparam int SLV_REGS    = 1;
    localparam int SLV_DEFAULT = 2;

    // memory map
    localparam logic [31:0] SRAM_BASE = 32'h0000_0000;
    localparam logic [31:0] SRAM_MASK = 32'h0000_03FF;
    localparam logic [31:0] REGS_BASE = 32'h4000_0000;
    localparam logic [31:0] REGS_MASK = 32'h0000_000F;

    localparam int SRAM_WORDS = 256;
    localparam int SRAM_AW    = $clog2(SRAM_WORDS);

    // read-only id register
    localparam logic [31:0] REG_ID_VALUE = 32'h0A5B_0001;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_e;

    typedef enum logic {
        HRESP_OKAY  = 1'b0,
        HRESP_ERROR = 1'b1
    } hresp_e;

    typedef enum logic [1:0] {
        DFLT_IDLE,
        DFLT_ERR1,
        DFLT_ERR2
    } dflt_state_e;

    // byte lanes touched by a transfer, little endian
    function automatic logic [3:0] byte_lanes(input hsize_e size, input logic [1:0] offset);
        logic [3:0] lanes;
        case (size)
            HSIZE_BYTE: lanes = 4'b0001 << offset;
            HSIZE_HALF: lanes = offset[1] ? 4'b1100 : 4'b0011;
            default:    lanes = 4'b1111;
        endcase
        return lanes;
    endfunction

endpackage
